//--- src/bp_pkg.sv
package bp_pkg;

    // ------------------------------------------------------------------------
    // Fetch geometry
    // ------------------------------------------------------------------------

    // Byte address width of the core
    localparam int CPU_ADDR_BITS = 32;

    // Sequential 32-bit instructions per fetch
    localparam int FETCH_WIDTH = 2;

    // First fetch address out of reset
    localparam logic [CPU_ADDR_BITS-1:0] RESET_PC = 32'h0000_1000;

    // Address step when no slot redirects
    localparam logic [CPU_ADDR_BITS-1:0] FETCH_BYTES = 32'd8;

    // ------------------------------------------------------------------------
    // Table sizes
    // ------------------------------------------------------------------------

    // Direct mapped, indexed by pc[7:2]
    localparam int BTB_ENTRIES = 64;

    // Tag taken from the bits just above the index
    localparam int BTB_TAG_WIDTH = 12;

    // 2-bit counters, indexed by pc[9:2]
    localparam int BHT_ENTRIES = 256;

    // ------------------------------------------------------------------------
    // Branch kinds held in the BTB
    // ------------------------------------------------------------------------

    // Only BT_COND consults the direction table;
    // the rest are always taken on a hit
    typedef enum logic [1:0] {
        BT_COND = 2'b00,
        BT_JUMP = 2'b01,
        BT_CALL = 2'b10,
        BT_RET  = 2'b11
    } branch_type_e;

endpackage

//--- src/btb.sv
`timescale 1ns/1ps

module btb (
    input  logic                          clk,
    input  logic                          rst,

    // Lookup, combinational
    input  logic [bp_pkg::CPU_ADDR_BITS-1:0] pc,
    output logic                          pred_hit     [bp_pkg::FETCH_WIDTH-1:0],
    output logic [bp_pkg::CPU_ADDR_BITS-1:0] pred_targs   [bp_pkg::FETCH_WIDTH-1:0],
    output bp_pkg::branch_type_e          pred_types   [bp_pkg::FETCH_WIDTH-1:0],

    // Training, written on the clock edge
    input  logic                          update_val   [bp_pkg::FETCH_WIDTH-1:0],
    input  logic [bp_pkg::CPU_ADDR_BITS-1:0] update_pc    [bp_pkg::FETCH_WIDTH-1:0],
    input  logic [bp_pkg::CPU_ADDR_BITS-1:0] update_targ  [bp_pkg::FETCH_WIDTH-1:0],
    input  bp_pkg::branch_type_e          update_type  [bp_pkg::FETCH_WIDTH-1:0],
    input  logic                          update_taken [bp_pkg::FETCH_WIDTH-1:0]
);

    import bp_pkg::*;

    typedef logic [$clog2(BTB_ENTRIES)-1:0] btb_idx_t;
    typedef logic [BTB_TAG_WIDTH-1:0]       btb_tag_t;

    // Index is pc[7:2], tag is the 12 bits above it
    function automatic btb_idx_t get_index(input logic [CPU_ADDR_BITS-1:0] addr);
        return addr[$bits(btb_idx_t)+1:2];
    endfunction

    function automatic btb_tag_t get_tag(input logic [CPU_ADDR_BITS-1:0] addr);
        return addr[BTB_TAG_WIDTH+$bits(btb_idx_t)+1:$bits(btb_idx_t)+2];
    endfunction

    // Entry storage
    logic                     ent_val  [BTB_ENTRIES-1:0];
    btb_tag_t                 ent_tag  [BTB_ENTRIES-1:0];
    logic [CPU_ADDR_BITS-1:0] ent_targ [BTB_ENTRIES-1:0];
    branch_type_e             ent_type [BTB_ENTRIES-1:0];

    // ------------------------------------------------------------------------
    // Lookup for each slot at pc + 4*slot
    // ------------------------------------------------------------------------
    logic [CPU_ADDR_BITS-1:0] lk_pc  [FETCH_WIDTH-1:0];
    btb_idx_t                 lk_idx [FETCH_WIDTH-1:0];
    btb_tag_t                 lk_tag [FETCH_WIDTH-1:0];

    always_comb begin
        for (int s = 0; s < FETCH_WIDTH; s++) begin
            lk_pc[s]      = pc + CPU_ADDR_BITS'(4 * s);
            lk_idx[s]     = get_index(lk_pc[s]);
            lk_tag[s]     = get_tag(lk_pc[s]);
            pred_hit[s]   = ent_val[lk_idx[s]] && (ent_tag[lk_idx[s]] == lk_tag[s]);
            pred_targs[s] = ent_targ[lk_idx[s]];
            pred_types[s] = ent_type[lk_idx[s]];
        end
    end

    // ------------------------------------------------------------------------
    // Update, only taken branches are installed
    // ------------------------------------------------------------------------
    logic     wr_en  [FETCH_WIDTH-1:0];
    btb_idx_t wr_idx [FETCH_WIDTH-1:0];

    always_comb begin
        for (int s = 0; s < FETCH_WIDTH; s++) begin
            wr_en[s]  = update_val[s] && update_taken[s];
            wr_idx[s] = get_index(update_pc[s]);
        end
    end

    for (genvar e = 0; e < BTB_ENTRIES; e++) begin : g_entry
        logic [FETCH_WIDTH-1:0] wr_sel;

        // Which slots target this entry
        always_comb begin
            for (int s = 0; s < FETCH_WIDTH; s++) begin
                wr_sel[s] = wr_en[s] && (wr_idx[s] == btb_idx_t'(e));
            end
        end

        always_ff @(posedge clk) begin
            if (rst) begin
                ent_val[e] <= 1'b0;
            end else if (|wr_sel) begin
                ent_val[e] <= 1'b1;
            end
        end

        // Later slot overwrites, so the younger instruction wins a collision
        always_ff @(posedge clk) begin
            for (int s = 0; s < FETCH_WIDTH; s++) begin
                if (wr_sel[s]) begin
                    ent_tag[e]  <= get_tag(update_pc[s]);
                    ent_targ[e] <= update_targ[s];
                    ent_type[e] <= update_type[s];
                end
            end
        end
    end

endmodule

//--- src/bimodal_bht.sv
`timescale 1ns/1ps

module bimodal_bht (
    input  logic                          clk,
    input  logic                          rst,

    // Lookup, combinational
    input  logic [bp_pkg::CPU_ADDR_BITS-1:0] pc,
    output logic                          pred_taken_dir [bp_pkg::FETCH_WIDTH-1:0],

    // Training from the back end
    input  logic                          update_val     [bp_pkg::FETCH_WIDTH-1:0],
    input  logic [bp_pkg::CPU_ADDR_BITS-1:0] update_pc      [bp_pkg::FETCH_WIDTH-1:0],
    input  bp_pkg::branch_type_e          update_type    [bp_pkg::FETCH_WIDTH-1:0],
    input  logic                          update_taken   [bp_pkg::FETCH_WIDTH-1:0]
);

    import bp_pkg::*;

    typedef logic [$clog2(BHT_ENTRIES)-1:0] bht_idx_t;

    // Saturating counter states
    typedef enum logic [1:0] {
        CTR_STRONG_NT = 2'b00,
        CTR_WEAK_NT   = 2'b01,
        CTR_WEAK_T    = 2'b10,
        CTR_STRONG_T  = 2'b11
    } ctr_e;

    // Index is pc[9:2]
    function automatic bht_idx_t get_index(input logic [CPU_ADDR_BITS-1:0] addr);
        return addr[$bits(bht_idx_t)+1:2];
    endfunction

    ctr_e ctr [BHT_ENTRIES-1:0];

    // ------------------------------------------------------------------------
    // Read both slots
    // ------------------------------------------------------------------------
    bht_idx_t rd_idx [FETCH_WIDTH-1:0];

    always_comb begin
        for (int s = 0; s < FETCH_WIDTH; s++) begin
            rd_idx[s]         = get_index(pc + CPU_ADDR_BITS'(4 * s));
            pred_taken_dir[s] = (ctr[rd_idx[s]] >= CTR_WEAK_T);
        end
    end

    // ------------------------------------------------------------------------
    // Saturating update, conditional branches only
    // ------------------------------------------------------------------------
    logic     upd_en   [FETCH_WIDTH-1:0];
    bht_idx_t upd_idx  [FETCH_WIDTH-1:0];
    ctr_e     upd_next [FETCH_WIDTH-1:0];

    always_comb begin
        for (int s = 0; s < FETCH_WIDTH; s++) begin
            upd_en[s]   = update_val[s] && (update_type[s] == BT_COND);
            upd_idx[s]  = get_index(update_pc[s]);
            upd_next[s] = ctr[upd_idx[s]];
            if (update_taken[s] && (ctr[upd_idx[s]] != CTR_STRONG_T)) begin
                upd_next[s] = ctr_e'(ctr[upd_idx[s]] + 2'd1);
            end else if (!update_taken[s] && (ctr[upd_idx[s]] != CTR_STRONG_NT)) begin
                upd_next[s] = ctr_e'(ctr[upd_idx[s]] - 2'd1);
            end
        end
    end

    // Slot 1 is applied last and wins on a shared counter
    always_ff @(posedge clk) begin
        if (rst) begin
            for (int e = 0; e < BHT_ENTRIES; e++) begin
                ctr[e] <= CTR_WEAK_NT;
            end
        end else begin
            for (int s = 0; s < FETCH_WIDTH; s++) begin
                if (upd_en[s]) begin
                    ctr[upd_idx[s]] <= upd_next[s];
                end
            end
        end
    end

endmodule

//--- src/next_pc_select.sv
`timescale 1ns/1ps

module next_pc_select (
    input  logic [bp_pkg::CPU_ADDR_BITS-1:0] fetch_pc,

    // Per-slot lookup results
    input  logic                          pred_hit       [bp_pkg::FETCH_WIDTH-1:0],
    input  logic [bp_pkg::CPU_ADDR_BITS-1:0] pred_targs     [bp_pkg::FETCH_WIDTH-1:0],
    input  bp_pkg::branch_type_e          pred_types     [bp_pkg::FETCH_WIDTH-1:0],
    input  logic                          pred_taken_dir [bp_pkg::FETCH_WIDTH-1:0],

    // Decision
    output logic [bp_pkg::CPU_ADDR_BITS-1:0] next_pc,
    output logic [bp_pkg::FETCH_WIDTH-1:0]   fetch_mask,
    output logic                          pred_taken
);

    import bp_pkg::*;

    // ------------------------------------------------------------------------
    // Per-slot redirect decision
    // ------------------------------------------------------------------------
    logic [FETCH_WIDTH-1:0] slot_redir;

    // Unconditional kinds always redirect on a hit
    always_comb begin
        for (int s = 0; s < FETCH_WIDTH; s++) begin
            slot_redir[s] = pred_hit[s] &&
                            ((pred_types[s] != BT_COND) || pred_taken_dir[s]);
        end
    end

    // ------------------------------------------------------------------------
    // Oldest redirecting slot picks the address and ends the fetch group
    // ------------------------------------------------------------------------
    logic older_redir;

    always_comb begin
        older_redir = 1'b0;
        for (int s = 0; s < FETCH_WIDTH; s++) begin
            fetch_mask[s] = !older_redir;
            older_redir   = older_redir || slot_redir[s];
        end
    end

    // Walk from the youngest so the oldest assignment stands
    always_comb begin
        next_pc = fetch_pc + FETCH_BYTES;
        for (int s = FETCH_WIDTH - 1; s >= 0; s--) begin
            if (slot_redir[s]) begin
                next_pc = pred_targs[s];
            end
        end
    end

    assign pred_taken = |slot_redir;

endmodule

//--- src/fetch_predictor.sv
`timescale 1ns/1ps

module fetch_predictor (
    input  logic                          clk,
    input  logic                          rst,

    // Back end control
    input  logic                          fetch_stall,
    input  logic                          redirect_val,
    input  logic [bp_pkg::CPU_ADDR_BITS-1:0] redirect_pc,

    // Training
    input  logic                          update_val   [bp_pkg::FETCH_WIDTH-1:0],
    input  logic [bp_pkg::CPU_ADDR_BITS-1:0] update_pc    [bp_pkg::FETCH_WIDTH-1:0],
    input  logic [bp_pkg::CPU_ADDR_BITS-1:0] update_targ  [bp_pkg::FETCH_WIDTH-1:0],
    input  bp_pkg::branch_type_e          update_type  [bp_pkg::FETCH_WIDTH-1:0],
    input  logic                          update_taken [bp_pkg::FETCH_WIDTH-1:0],

    // Fetch request and prediction
    output logic                          fetch_val,
    output logic [bp_pkg::CPU_ADDR_BITS-1:0] fetch_pc,
    output logic [bp_pkg::FETCH_WIDTH-1:0]   fetch_mask,
    output logic                          pred_taken,
    output logic [bp_pkg::CPU_ADDR_BITS-1:0] next_pc
);

    import bp_pkg::*;

    logic                     pred_hit       [FETCH_WIDTH-1:0];
    logic [CPU_ADDR_BITS-1:0] pred_targs     [FETCH_WIDTH-1:0];
    branch_type_e             pred_types     [FETCH_WIDTH-1:0];
    logic                     pred_taken_dir [FETCH_WIDTH-1:0];

    // ------------------------------------------------------------------------
    // Predictor tables and selection
    // ------------------------------------------------------------------------
    btb btb0 (
        .clk, .rst, .pc(fetch_pc),
        .pred_hit, .pred_targs, .pred_types,
        .update_val, .update_pc, .update_targ, .update_type, .update_taken
    );

    bimodal_bht bht0 (
        .clk, .rst, .pc(fetch_pc),
        .pred_taken_dir,
        .update_val, .update_pc, .update_type, .update_taken
    );

    next_pc_select sel0 (
        .fetch_pc, .pred_hit, .pred_targs, .pred_types, .pred_taken_dir,
        .next_pc, .fetch_mask, .pred_taken
    );

    // ------------------------------------------------------------------------
    // Fetch address register
    // ------------------------------------------------------------------------
    // Redirect beats stall
    always_ff @(posedge clk) begin
        if (rst) begin
            fetch_pc  <= RESET_PC;
            fetch_val <= 1'b0;
        end else begin
            fetch_val <= 1'b1;
            if (redirect_val) begin
                fetch_pc <= redirect_pc;
            end else if (!fetch_stall) begin
                fetch_pc <= next_pc;
            end
        end
    end

endmodule

//--- verif/fetch_predictor_tb.sv
`timescale 1ns/1ps

module fetch_predictor_tb;

    import bp_pkg::*;

    logic                     clk = 1'b0;
    logic                     rst;
    logic                     fetch_stall;
    logic                     redirect_val;
    logic [CPU_ADDR_BITS-1:0] redirect_pc;
    logic                     update_val   [FETCH_WIDTH-1:0];
    logic [CPU_ADDR_BITS-1:0] update_pc    [FETCH_WIDTH-1:0];
    logic [CPU_ADDR_BITS-1:0] update_targ  [FETCH_WIDTH-1:0];
    branch_type_e             update_type  [FETCH_WIDTH-1:0];
    logic                     update_taken [FETCH_WIDTH-1:0];
    logic                     fetch_val;
    logic [CPU_ADDR_BITS-1:0] fetch_pc;
    logic [FETCH_WIDTH-1:0]   fetch_mask;
    logic                     pred_taken;
    logic [CPU_ADDR_BITS-1:0] next_pc;

    int checks = 0;
    int errors = 0;

    fetch_predictor dut0 (
        .clk, .rst, .fetch_stall, .redirect_val, .redirect_pc,
        .update_val, .update_pc, .update_targ, .update_type, .update_taken,
        .fetch_val, .fetch_pc, .fetch_mask, .pred_taken, .next_pc
    );

    always #2 clk = ~clk;

    // ------------------------------------------------------------------------
    // Reference model of the tables and the fetch address
    // ------------------------------------------------------------------------
    logic                     m_val  [64];
    logic [11:0]              m_tag  [64];
    logic [CPU_ADDR_BITS-1:0] m_targ [64];
    branch_type_e             m_type [64];
    logic [1:0]               m_ctr  [256];
    logic [CPU_ADDR_BITS-1:0] m_pc;
    logic [CPU_ADDR_BITS-1:0] exp_next_pc;
    logic [FETCH_WIDTH-1:0]   exp_mask;
    logic                     exp_taken;

    function automatic logic [1:0] saturate_counter(input logic [1:0] c, input logic taken);
        if (taken) begin
            return (c == 2'd3) ? c : c + 2'd1;
        end
        return (c == 2'd0) ? c : c - 2'd1;
    endfunction

    always_comb begin
        logic [CPU_ADDR_BITS-1:0] slot_pc;
        logic                     redir [2];
        logic [CPU_ADDR_BITS-1:0] targ  [2];
        for (int s = 0; s < 2; s++) begin
            slot_pc  = m_pc + 32'(4 * s);
            targ[s]  = m_targ[slot_pc[7:2]];
            redir[s] = m_val[slot_pc[7:2]] && (m_tag[slot_pc[7:2]] == slot_pc[19:8]) &&
                       ((m_type[slot_pc[7:2]] != BT_COND) || (m_ctr[slot_pc[9:2]] >= 2'd2));
        end
        if (redir[0]) begin
            exp_next_pc = targ[0];
            exp_mask    = 2'b01;
            exp_taken   = 1'b1;
        end else if (redir[1]) begin
            exp_next_pc = targ[1];
            exp_mask    = 2'b11;
            exp_taken   = 1'b1;
        end else begin
            exp_next_pc = m_pc + FETCH_BYTES;
            exp_mask    = 2'b11;
            exp_taken   = 1'b0;
        end
    end

    always @(posedge clk) begin
        if (rst) begin
            m_pc <= RESET_PC;
            for (int e = 0; e < 64; e++) begin
                m_val[e] <= 1'b0;
            end
            for (int e = 0; e < 256; e++) begin
                m_ctr[e] <= 2'b01;
            end
        end else begin
            if (redirect_val) begin
                m_pc <= redirect_pc;
            end else if (!fetch_stall) begin
                m_pc <= exp_next_pc;
            end
            // Slot 1 goes last and wins a shared entry
            for (int s = 0; s < 2; s++) begin
                if (update_val[s] && update_taken[s]) begin
                    m_val[update_pc[s][7:2]]  <= 1'b1;
                    m_tag[update_pc[s][7:2]]  <= update_pc[s][19:8];
                    m_targ[update_pc[s][7:2]] <= update_targ[s];
                    m_type[update_pc[s][7:2]] <= update_type[s];
                end
                if (update_val[s] && (update_type[s] == BT_COND)) begin
                    m_ctr[update_pc[s][9:2]] <=
                        saturate_counter(m_ctr[update_pc[s][9:2]], update_taken[s]);
                end
            end
        end
    end

    // ------------------------------------------------------------------------
    // Checks
    // ------------------------------------------------------------------------
    task automatic report_mismatch(input string what, input logic [31:0] got,
                                   input logic [31:0] exp);
        errors++;
        $display("Fail at %0t ns: %s is %h, expected %h", $time, what, got, exp);
    endtask

    always @(posedge clk) begin
        if (!rst && fetch_val) begin
            checks++;
        end
    end

    pc_follows_model: assert property (@(posedge clk) disable iff (rst)
        fetch_val |-> (fetch_pc == m_pc))
        else report_mismatch("fetch_pc", $sampled(fetch_pc), $sampled(m_pc));
    next_pc_matches: assert property (@(posedge clk) disable iff (rst)
        fetch_val |-> (next_pc == exp_next_pc))
        else report_mismatch("next_pc", $sampled(next_pc), $sampled(exp_next_pc));
    mask_matches: assert property (@(posedge clk) disable iff (rst)
        fetch_val |-> (fetch_mask == exp_mask))
        else report_mismatch("fetch_mask", 32'($sampled(fetch_mask)), 32'($sampled(exp_mask)));
    taken_matches: assert property (@(posedge clk) disable iff (rst)
        fetch_val |-> (pred_taken == exp_taken))
        else report_mismatch("pred_taken", 32'($sampled(pred_taken)), 32'($sampled(exp_taken)));

    // Directed expectations sampled between edges
    task automatic expect_prediction(input logic [CPU_ADDR_BITS-1:0] exp_next,
                                     input logic [FETCH_WIDTH-1:0] exp_m, input logic exp_t);
        assert (next_pc == exp_next) else report_mismatch("next_pc", next_pc, exp_next);
        assert (fetch_mask == exp_m)
            else report_mismatch("fetch_mask", 32'(fetch_mask), 32'(exp_m));
        assert (pred_taken == exp_t)
            else report_mismatch("pred_taken", 32'(pred_taken), 32'(exp_t));
    endtask

    // ------------------------------------------------------------------------
    // Stimulus helpers
    // ------------------------------------------------------------------------
    task automatic set_update(input int s, input logic [CPU_ADDR_BITS-1:0] pc,
                              input logic [CPU_ADDR_BITS-1:0] targ, input branch_type_e t,
                              input logic taken);
        update_val[s]   = 1'b1;
        update_pc[s]    = pc;
        update_targ[s]  = targ;
        update_type[s]  = t;
        update_taken[s] = taken;
    endtask

    // One cycle and then the strobes drop
    task automatic next_cycle();
        @(negedge clk);
        redirect_val = 1'b0;
        for (int s = 0; s < FETCH_WIDTH; s++) begin
            update_val[s] = 1'b0;
        end
    endtask

    task automatic redirect_to(input logic [CPU_ADDR_BITS-1:0] pc);
        redirect_val = 1'b1;
        redirect_pc  = pc;
        next_cycle();
    endtask

    // Small window with two tags per index so random traffic keeps hitting
    function automatic logic [CPU_ADDR_BITS-1:0] pick_addr();
        return 32'h0000_1000 + (($urandom % 128) << 2);
    endfunction

    initial begin
        int waited;
        void'($urandom(32'hf4fd));
        rst          = 1'b1;
        fetch_stall  = 1'b1;
        redirect_val = 1'b0;
        redirect_pc  = '0;
        for (int s = 0; s < FETCH_WIDTH; s++) begin
            update_val[s]   = 1'b0;
            update_pc[s]    = '0;
            update_targ[s]  = '0;
            update_type[s]  = BT_COND;
            update_taken[s] = 1'b0;
        end
        repeat (10) @(posedge clk);
        @(negedge clk);
        assert (fetch_val === 1'b0)
            else report_mismatch("fetch_val", 32'(fetch_val), 32'd0);
        rst = 1'b0;

        // Stall held across reset release so RESET_PC is presented valid
        waited = 0;
        while (fetch_val !== 1'b1 && waited < 20) begin
            @(negedge clk);
            waited++;
        end
        if (fetch_val !== 1'b1) begin
            $display("Timeout: fetch_val did not rise after reset");
            $display("SIMULATION FAILED");
            $finish;
        end
        assert (fetch_pc == RESET_PC) else report_mismatch("fetch_pc", fetch_pc, RESET_PC);
        fetch_stall = 1'b0;
        repeat (4) next_cycle();
        assert (fetch_pc == RESET_PC + 32'd32)
            else report_mismatch("fetch_pc", fetch_pc, RESET_PC + 32'd32);
        expect_prediction(RESET_PC + 32'd32 + FETCH_BYTES, 2'b11, 1'b0);

        // Taken jump at slot 0 and then an alias with another tag
        set_update(0, 32'h0000_2040, 32'h0000_3000, BT_JUMP, 1'b1);
        next_cycle();
        redirect_to(32'h0000_2040);
        expect_prediction(32'h0000_3000, 2'b01, 1'b1);
        redirect_to(32'h0000_2140);
        expect_prediction(32'h0000_2148, 2'b11, 1'b0);

        // Conditional at slot 1 trained taken and then not taken
        set_update(0, 32'h0000_2204, 32'h0000_3400, BT_COND, 1'b1);
        next_cycle();
        redirect_to(32'h0000_2200);
        expect_prediction(32'h0000_3400, 2'b11, 1'b1);
        set_update(1, 32'h0000_2204, 32'h0000_3800, BT_COND, 1'b0);
        next_cycle();
        redirect_to(32'h0000_2200);
        expect_prediction(32'h0000_2208, 2'b11, 1'b0);
        assert (dut0.btb0.ent_targ[1] == 32'h0000_3400)
            else report_mismatch("btb target", dut0.btb0.ent_targ[1], 32'h0000_3400);

        // Slot 1 must win entry and counter on same-cycle collisions
        set_update(0, 32'h0000_2300, 32'h0000_4000, BT_CALL, 1'b1);
        set_update(1, 32'h0000_2300, 32'h0000_4100, BT_COND, 1'b1);
        next_cycle();
        redirect_to(32'h0000_2300);
        expect_prediction(32'h0000_4100, 2'b01, 1'b1);
        // Weakened counter exposes the stored type
        set_update(0, 32'h0000_2300, 32'h0000_4000, BT_COND, 1'b0);
        next_cycle();
        redirect_to(32'h0000_2300);
        expect_prediction(32'h0000_2308, 2'b11, 1'b0);
        set_update(0, 32'h0000_2510, 32'h0000_4200, BT_COND, 1'b0);
        set_update(1, 32'h0000_2510, 32'h0000_4300, BT_COND, 1'b1);
        next_cycle();
        redirect_to(32'h0000_2510);
        expect_prediction(32'h0000_4300, 2'b01, 1'b1);

        // Stall holds and a redirect overrides it
        fetch_stall = 1'b1;
        repeat (3) next_cycle();
        assert (fetch_pc == 32'h0000_2510)
            else report_mismatch("fetch_pc", fetch_pc, 32'h0000_2510);
        redirect_to(32'h0000_5000);
        assert (fetch_pc == 32'h0000_5000)
            else report_mismatch("fetch_pc", fetch_pc, 32'h0000_5000);
        next_cycle();
        assert (fetch_pc == 32'h0000_5000)
            else report_mismatch("fetch_pc", fetch_pc, 32'h0000_5000);
        fetch_stall = 1'b0;

        // Random traffic
        for (int i = 0; i < 400; i++) begin
            for (int s = 0; s < FETCH_WIDTH; s++) begin
                if ($urandom % 3 == 0) begin
                    set_update(s, pick_addr(), pick_addr(),
                               branch_type_e'(2'($urandom % 4)), 1'($urandom % 2));
                end
            end
            fetch_stall = ($urandom % 8) == 0;
            if ($urandom % 16 == 0) begin
                redirect_val = 1'b1;
                redirect_pc  = pick_addr();
            end
            next_cycle();
        end
        fetch_stall = 1'b0;
        repeat (4) next_cycle();

        $display("Checked %0d cycles, %0d errors", checks, errors);
        if (errors == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

endmodule

//--- list.f
src/bp_pkg.sv
src/btb.sv
src/bimodal_bht.sv
src/next_pc_select.sv
src/fetch_predictor.sv
verif/fetch_predictor_tb.sv

//--- run.sh
#!/usr/bin/env bash
cd "$(dirname "$0")" \
    && verilator --binary --timing --assert -f list.f \
        --top-module fetch_predictor_tb -o fetch_predictor_sim \
    && ./obj_dir/fetch_predictor_sim | tee /dev/stderr | grep -x "SIMULATION PASSED" > /dev/null \
    && echo "Run passed" \
    || { echo "Run failed"; exit 1; }
